/* ucpd_bmc_phy.f */
hw/ucpd_bmc_pkg.sv
hw/cc_line_sampler.sv
hw/ui_trainer.sv
hw/bmc_bit_decoder.sv
hw/bmc_encoder.sv
hw/rx_phy_ctrl.sv
hw/ucpd_bmc_phy.sv
+incdir+bench
bench/ucpd_bmc_tb.sv

/* Makefile */
# Verilator build for the ucpd_bmc_phy project

VERILATOR ?= verilator
FLAGS     ?= --assert --timing
TOP       ?= ucpd_bmc_tb
FILELIST  ?= ucpd_bmc_phy.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/bmc_line_model.svh */
`ifndef BMC_LINE_MODEL_SVH
`define BMC_LINE_MODEL_SVH

// --------------------
// line generator
// --------------------
// one line interval, the toggle at its start is the edge
task automatic drive_interval(input int len, input bit glitch);
  int i;
  cc_level = !cc_level;
  for (i = 0; i < len; i++) begin
    @(negedge ucpd_clk);
    // glitch kept clear of the filter settle window
    if (glitch && (len >= 7) && (i == len / 2))
      cc_in = !cc_level;
    else
      cc_in = cc_level;
    eop       = (i == 0) && (pulse_sel == 1);
    hard_rst  = (i == 0) && (pulse_sel == 2);
    cable_rst = (i == 0) && (pulse_sel == 3);
    if ((i == 2) && (pulse_sel != 0)) begin
      if (receive_en) begin
        $display("Error %0t: receive_en still high after termination", $time);
        errors++;
      end
      watch_abort = 1'b1;
      pulse_sel   = 0;
    end
  end
endtask

// bit 0 is one long interval, bit 1 two short ones, jitter of one cycle
task automatic send_bit(input bit value, input bit glitch_en);
  int jit;
  jit = int'($urandom_range(2)) - 1;
  if (!value) begin
    drive_interval(2 * half_len + jit, glitch_en && ($urandom_range(3) == 0));
  end else begin
    drive_interval(half_len + jit, glitch_en && ($urandom_range(3) == 0));
    jit = int'($urandom_range(2)) - 1;
    drive_interval(half_len + jit, glitch_en && ($urandom_range(3) == 0));
  end
endtask

// --------------------
// transmit checker
// --------------------
// cc_out sampled each cycle, then cut into bits of known length
task automatic run_tx_check(input int nbits);
  bit sent[$];
  bit samp[$];
  bit prev_req;
  bit last;
  bit got;
  int c;
  int s;
  int b;
  int k;
  prev_req = 1'b0;
  tx_bit   = 1'($urandom_range(1));
  tx_en    = 1'b1;
  for (c = 0; c < nbits * 2 * tx_half + 24; c++) begin
    @(negedge ucpd_clk);
    samp.push_back(cc_out);
    // the bit was taken at the last posedge
    if (prev_req)
      tx_bit = 1'($urandom_range(1));
    prev_req = tx_bit_req;
    if (tx_bit_req)
      sent.push_back(tx_bit);
  end
  tx_en = 1'b0;
  s = -1;
  last = 1'b0;
  for (c = 0; (c < samp.size()) && (s < 0); c++) begin
    if (samp[c] != last)
      s = c;
    last = samp[c];
  end
  k = 0;
  b = s;
  while ((s >= 0) && (b + tx_half < samp.size()) && (k < sent.size())) begin
    if ((k > 0) && (samp[b] == samp[b-1])) begin
      $display("Error %0t: no transition at start of tx bit %0d", $time, k);
      errors++;
    end
    got = (samp[b+tx_half] != samp[b+tx_half-1]);
    if (got != sent[k]) begin
      $display("Error %0t: tx bit %0d decoded %0d, sent %0d", $time, k, got, sent[k]);
      errors++;
    end
    k++;
    b = b + 2 * tx_half;
  end
  if (k < nbits - 2) begin
    $display("Error %0t: only %0d tx bits found on cc_out", $time, k);
    errors++;
  end
endtask

`endif

/* bench/ucpd_bmc_tb.sv */
`timescale 1ns/1ns

module ucpd_bmc_tb;

  localparam int tx_half     = 8;
  localparam int idle_cycles = 64;
  localparam int pkt_bits    = 104;
  // ten packets and one transmit run, slowest half bit of 10 cycles
  localparam int total_bits  = 10 * pkt_bits + 60;
  localparam longint limit_ns = longint'(total_bits * 20 + 12 * 300 + 2000) * 100;

  logic                     ucpd_clk;
  logic                     ic_rst_n;
  logic                     cc_in;
  ucpd_bmc_pkg::filt_mode_e filt_mode;
  logic                     phy_rx_en;
  logic                     hard_rst;
  logic                     cable_rst;
  logic                     eop;
  logic                     tx_en;
  logic                     tx_bit;
  ucpd_bmc_pkg::rx_bit_t    rx_bit;
  logic                     receive_en;
  logic                     cc_out;
  logic                     tx_bit_req;

  // model state
  bit  cc_level;
  int  half_len;
  int  pulse_sel;
  bit  glitch_on;
  bit  watch_abort;
  bit  rx_seen;
  int  late_bits;
  bit  payload[$];
  bit  rx_q[$];
  int  errors;
  int  tests_run;
  int  tests_failed;
  int  e0;

  ucpd_bmc_phy #(
    .HALF_BIT_CYCLES (tx_half),
    .IDLE_CYCLES     (idle_cycles)
  ) ucpd_bmc_phy_i (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .cc_in      (cc_in),
    .filt_mode  (filt_mode),
    .phy_rx_en  (phy_rx_en),
    .hard_rst   (hard_rst),
    .cable_rst  (cable_rst),
    .eop        (eop),
    .tx_en      (tx_en),
    .tx_bit     (tx_bit),
    .rx_bit     (rx_bit),
    .receive_en (receive_en),
    .cc_out     (cc_out),
    .tx_bit_req (tx_bit_req)
  );

  `include "bmc_line_model.svh"

  always #50 ucpd_clk = !ucpd_clk;

  // outputs move on posedge, look at them half a cycle later
  always @(negedge ucpd_clk) begin
    if (rx_bit.valid) begin
      rx_q.push_back(rx_bit.value);
      if (watch_abort)
        late_bits++;
    end
    if (receive_en)
      rx_seen = 1'b1;
  end

  initial begin
    #(limit_ns);
    $display("watchdog: run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  // --------------------
  // packet tasks
  // --------------------
  // abort_bit < 0 sends the whole packet and a closing edge
  task automatic send_packet(input int abort_bit, input int kind, input bit expect_rx);
    int i;
    bit b;
    half_len = int'($urandom_range(10, 6));
    rx_q.delete();
    payload.delete();
    watch_abort = 1'b0;
    late_bits   = 0;
    rx_seen     = 1'b0;
    for (i = 0; i < 64; i++)
      send_bit(1'(i % 2), 1'b0);
    if (expect_rx && !receive_en) begin
      $display("Error %0t: receive_en low at end of preamble", $time);
      errors++;
    end
    for (i = 0; i < 40; i++) begin
      b = 1'($urandom_range(1));
      payload.push_back(b);
      if (i == abort_bit)
        pulse_sel = kind;
      send_bit(b, glitch_on);
    end
    // last bit ends on one more edge
    drive_interval(1, 1'b0);
  endtask

  // receive_en must drop on its own, then give the line time to rearm
  task automatic wait_line_idle;
    int n;
    n = 0;
    while (receive_en && (n < idle_cycles + 10)) begin
      @(negedge ucpd_clk);
      n++;
    end
    if (receive_en) begin
      $display("Error %0t: receive_en did not fall after line idle", $time);
      errors++;
    end
    repeat (idle_cycles + 10) @(negedge ucpd_clk);
  endtask

  task automatic check_payload;
    int off;
    int i;
    // closing edge needs up to six cycles to come out as a bit
    repeat (8) @(negedge ucpd_clk);
    if (rx_q.size() < payload.size()) begin
      $display("Error %0t: only %0d bits decoded", $time, rx_q.size());
      errors++;
    end else begin
      off = rx_q.size() - payload.size();
      for (i = 0; i < payload.size(); i++) begin
        if (rx_q[off+i] !== payload[i]) begin
          $display("Error %0t: payload bit %0d got %0d, expected %0d",
                   $time, i, rx_q[off+i], payload[i]);
          errors++;
        end
      end
    end
  endtask

  task automatic report_test(input string name, input int errs);
    tests_run++;
    if (errs != 0)
      tests_failed++;
    $display("test %s: %s (%0d errors)", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    void'($urandom(32'h6ca1_baf7));
    ucpd_clk  = 1'b0;
    ic_rst_n  = 1'b0;
    cc_in     = 1'b0;
    filt_mode = ucpd_bmc_pkg::filt_bypass;
    phy_rx_en = 1'b1;
    hard_rst  = 1'b0;
    cable_rst = 1'b0;
    eop       = 1'b0;
    tx_en     = 1'b0;
    tx_bit    = 1'b0;
    cc_level  = 1'b0;
    pulse_sel = 0;
    glitch_on = 1'b0;
    errors    = 0;
    repeat (2) @(negedge ucpd_clk);
    ic_rst_n = 1'b1;
    repeat (4) @(negedge ucpd_clk);

    e0 = errors;
    run_tx_check(60);
    report_test("transmit", errors - e0);

    e0 = errors;
    filt_mode = ucpd_bmc_pkg::filt_bypass;
    send_packet(-1, 0, 1'b1);
    check_payload();
    wait_line_idle();
    filt_mode = ucpd_bmc_pkg::filt_2of3;
    send_packet(-1, 0, 1'b1);
    check_payload();
    wait_line_idle();
    filt_mode = ucpd_bmc_pkg::filt_3of3;
    send_packet(-1, 0, 1'b1);
    check_payload();
    wait_line_idle();
    report_test("receive", errors - e0);

    e0 = errors;
    glitch_on = 1'b1;
    filt_mode = ucpd_bmc_pkg::filt_2of3;
    send_packet(-1, 0, 1'b1);
    check_payload();
    wait_line_idle();
    filt_mode = ucpd_bmc_pkg::filt_3of3;
    send_packet(-1, 0, 1'b1);
    check_payload();
    wait_line_idle();
    glitch_on = 1'b0;
    report_test("glitch", errors - e0);

    // eop, hard reset, cable reset in turn
    e0 = errors;
    for (int k = 1; k <= 3; k++) begin
      send_packet(10 + k, k, 1'b1);
      wait_line_idle();
      if (late_bits != 0) begin
        $display("Error %0t: %0d bits decoded after termination", $time, late_bits);
        errors++;
      end
    end
    report_test("termination", errors - e0);

    e0 = errors;
    send_packet(-1, 0, 1'b1);
    wait_line_idle();
    phy_rx_en = 1'b0;
    send_packet(-1, 0, 1'b0);
    wait_line_idle();
    if (rx_seen || (rx_q.size() != 0)) begin
      $display("Error %0t: receiver active with phy_rx_en low", $time);
      errors++;
    end
    phy_rx_en = 1'b1;
    report_test("idle", errors - e0);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* hw/ucpd_bmc_phy.sv */
`timescale 1ns/1ns

module ucpd_bmc_phy #(
  parameter int HALF_BIT_CYCLES = ucpd_bmc_pkg::default_half_bit_cycles,
  parameter int IDLE_CYCLES     = ucpd_bmc_pkg::default_idle_cycles
) (
  input  logic                     ucpd_clk,
  input  logic                     ic_rst_n,
  input  logic                     cc_in,
  input  ucpd_bmc_pkg::filt_mode_e filt_mode,
  input  logic                     phy_rx_en,
  input  logic                     hard_rst,
  input  logic                     cable_rst,
  input  logic                     eop,
  input  logic                     tx_en,
  input  logic                     tx_bit,
  output ucpd_bmc_pkg::rx_bit_t    rx_bit,
  output logic                     receive_en,
  output logic                     cc_out,
  output logic                     tx_bit_req
);

  // filtered line events, shared by the whole receive side
  ucpd_bmc_pkg::cc_edge_t  cc_edge;
  ucpd_bmc_pkg::interval_t ui_threshold;
  logic                    train_done;
  logic                    train_en;
  logic                    decode_en;

  // --------------------
  // receive path
  // --------------------
  cc_line_sampler #(
    .IDLE_CYCLES (IDLE_CYCLES)
  ) cc_line_sampler_i (
    .ucpd_clk  (ucpd_clk),
    .ic_rst_n  (ic_rst_n),
    .cc_in     (cc_in),
    .filt_mode (filt_mode),
    .cc_edge   (cc_edge)
  );

  // unit interval learned from the preamble
  ui_trainer ui_trainer_i (
    .ucpd_clk     (ucpd_clk),
    .ic_rst_n     (ic_rst_n),
    .cc_edge      (cc_edge),
    .train_en     (train_en),
    .ui_threshold (ui_threshold),
    .train_done   (train_done)
  );

  bmc_bit_decoder bmc_bit_decoder_i (
    .ucpd_clk     (ucpd_clk),
    .ic_rst_n     (ic_rst_n),
    .cc_edge      (cc_edge),
    .ui_threshold (ui_threshold),
    .decode_en    (decode_en),
    .rx_bit       (rx_bit)
  );

  // idle / train / receive sequencing
  rx_phy_ctrl rx_phy_ctrl_i (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .cc_edge    (cc_edge),
    .train_done (train_done),
    .phy_rx_en  (phy_rx_en),
    .hard_rst   (hard_rst),
    .cable_rst  (cable_rst),
    .eop        (eop),
    .train_en   (train_en),
    .decode_en  (decode_en),
    .receive_en (receive_en)
  );

  // --------------------
  // transmit path
  // --------------------
  bmc_encoder #(
    .HALF_BIT_CYCLES (HALF_BIT_CYCLES)
  ) bmc_encoder_i (
    .ucpd_clk   (ucpd_clk),
    .ic_rst_n   (ic_rst_n),
    .tx_en      (tx_en),
    .tx_bit     (tx_bit),
    .cc_out     (cc_out),
    .tx_bit_req (tx_bit_req)
  );

endmodule

/* hw/rx_phy_ctrl.sv */
`timescale 1ns/1ns

module rx_phy_ctrl (
  input  logic                   ucpd_clk,
  input  logic                   ic_rst_n,
  input  ucpd_bmc_pkg::cc_edge_t cc_edge,
  input  logic                   train_done,
  input  logic                   phy_rx_en,
  input  logic                   hard_rst,
  input  logic                   cable_rst,
  input  logic                   eop,
  output logic                   train_en,
  output logic                   decode_en,
  output logic                   receive_en
);

  ucpd_bmc_pkg::rx_state_e state_q;
  ucpd_bmc_pkg::rx_state_e state_nxt;
  logic                    abort;
  // line was quiet since the last packet started
  logic                    armed;

  assign abort = cc_edge.idle || eop || hard_rst || cable_rst || !phy_rx_en;

  // --------------------
  // next state
  // --------------------
  always_comb begin
    state_nxt = state_q;
    if (abort) begin
      state_nxt = ucpd_bmc_pkg::rx_idle;
    end else begin
      case (state_q)
        ucpd_bmc_pkg::rx_idle: begin
          // a cut-off packet may keep toggling, wait for quiet first
          if (cc_edge.edge_pulse && armed)
            state_nxt = ucpd_bmc_pkg::rx_train;
        end
        ucpd_bmc_pkg::rx_train: begin
          if (train_done)
            state_nxt = ucpd_bmc_pkg::rx_receive;
        end
        ucpd_bmc_pkg::rx_receive: state_nxt = ucpd_bmc_pkg::rx_receive;
        default: state_nxt = ucpd_bmc_pkg::rx_idle;
      endcase
    end
  end

  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      state_q <= ucpd_bmc_pkg::rx_idle;
      armed   <= 1'b1;
    end else begin
      state_q <= state_nxt;
      if (cc_edge.idle)
        armed <= 1'b1;
      else if ((state_q == ucpd_bmc_pkg::rx_idle) && (state_nxt == ucpd_bmc_pkg::rx_train))
        armed <= 1'b0;
    end
  end

  // straight state decode
  assign train_en   = (state_q == ucpd_bmc_pkg::rx_train);
  assign decode_en  = (state_q == ucpd_bmc_pkg::rx_receive);
  assign receive_en = (state_q == ucpd_bmc_pkg::rx_receive);

  a_state_legal: assert property (
    @(posedge ucpd_clk) disable iff (!ic_rst_n)
    state_q inside {ucpd_bmc_pkg::rx_idle, ucpd_bmc_pkg::rx_train, ucpd_bmc_pkg::rx_receive});

endmodule

/* hw/bmc_encoder.sv */
`timescale 1ns/1ns

module bmc_encoder #(
  parameter int HALF_BIT_CYCLES = ucpd_bmc_pkg::default_half_bit_cycles
) (
  input  logic ucpd_clk,
  input  logic ic_rst_n,
  input  logic tx_en,
  input  logic tx_bit,
  output logic cc_out,
  output logic tx_bit_req
);

  localparam int div_w = (HALF_BIT_CYCLES > 1) ? $clog2(HALF_BIT_CYCLES) : 1;
  localparam logic [div_w-1:0] div_last = div_w'(HALF_BIT_CYCLES - 1);

  logic [div_w-1:0] div_cnt;
  logic             div_wrap;
  // set while in the second half, next wrap is a bit start
  logic             second_half;
  logic             bit_q;
  logic             line_q;

  assign div_wrap   = tx_en && (div_cnt == div_last);
  // bit sampled in this very cycle, ask for the next
  assign tx_bit_req = div_wrap && second_half;
  assign cc_out     = line_q;

  // --------------------
  // divider and toggle
  // --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      div_cnt     <= '0;
      second_half <= 1'b1;
      bit_q       <= 1'b0;
      line_q      <= 1'b0;
    end else if (!tx_en) begin
      // parked low, first wrap after enable starts a bit
      div_cnt     <= '0;
      second_half <= 1'b1;
      line_q      <= 1'b0;
    end else if (div_wrap) begin
      div_cnt     <= '0;
      second_half <= !second_half;
      if (second_half) begin
        // bit start, always a transition
        bit_q  <= tx_bit;
        line_q <= !line_q;
      end else if (bit_q) begin
        // mid-bit transition for a 1
        line_q <= !line_q;
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

/* hw/bmc_bit_decoder.sv */
`timescale 1ns/1ns

module bmc_bit_decoder (
  input  logic                    ucpd_clk,
  input  logic                    ic_rst_n,
  input  ucpd_bmc_pkg::cc_edge_t  cc_edge,
  input  ucpd_bmc_pkg::interval_t ui_threshold,
  input  logic                    decode_en,
  output ucpd_bmc_pkg::rx_bit_t   rx_bit
);

  // first short of a 1 bit seen
  logic                  half_flag;
  logic                  is_long;
  ucpd_bmc_pkg::rx_bit_t bit_q;

  // above 3/4 UI is a full bit without mid transition
  assign is_long = cc_edge.interval > ui_threshold;

  // --------------------
  // classify
  // --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      half_flag <= 1'b0;
      bit_q     <= '0;
    end else begin
      bit_q.valid <= 1'b0;
      if (!decode_en) begin
        half_flag <= 1'b0;
      end else if (cc_edge.edge_pulse) begin
        if (is_long) begin
          // long one, bit 0
          // also resyncs a dangling half
          bit_q.valid <= 1'b1;
          bit_q.value <= 1'b0;
          half_flag   <= 1'b0;
        end else if (half_flag) begin
          // second short closes a 1
          bit_q.valid <= 1'b1;
          bit_q.value <= 1'b1;
          half_flag   <= 1'b0;
        end else begin
          half_flag <= 1'b1;
        end
      end
    end
  end

  assign rx_bit = bit_q;

  // a bit only ever comes from an edge seen while decoding
  a_bit_from_decode_edge: assert property (
    @(posedge ucpd_clk) disable iff (!ic_rst_n)
    rx_bit.valid |-> $past(decode_en) && $past(cc_edge.edge_pulse));

endmodule

/* hw/ui_trainer.sv */
`timescale 1ns/1ns

module ui_trainer (
  input  logic                    ucpd_clk,
  input  logic                    ic_rst_n,
  input  ucpd_bmc_pkg::cc_edge_t  cc_edge,
  input  logic                    train_en,
  output ucpd_bmc_pkg::interval_t ui_threshold,
  output logic                    train_done
);

  localparam int iw    = ucpd_bmc_pkg::interval_w;
  localparam int sum_w = iw + 2;
  localparam int cnt_w = $clog2(ucpd_bmc_pkg::train_samples);

  // two older intervals, the newest one is on cc_edge
  ucpd_bmc_pkg::interval_t win_a;
  ucpd_bmc_pkg::interval_t win_b;
  logic [1:0]              fill;
  logic [cnt_w-1:0]        acc_cnt;
  ucpd_bmc_pkg::ui_sum_t   acc_sum;
  ucpd_bmc_pkg::ui_sum_t   acc_sum_nxt;
  logic                    done_q;
  logic                    take;
  logic                    mid_peak;
  logic                    win_ok;
  logic [sum_w-1:0]        win_sum;
  logic [sum_w+1:0]        win_sum_x3;
  logic [iw:0]             thr_full;
  ucpd_bmc_pkg::interval_t win_thr;

  assign take = cc_edge.edge_pulse && train_en && !done_q;

  // --------------------
  // window check
  // --------------------
  // a long interval in the middle means a lost short, reject
  assign mid_peak = (win_b > win_a) && (win_b > cc_edge.interval);
  assign win_ok   = (fill == 2'd3) && !mid_peak;

  // window covers two bit times, 3/8 of it is 3/4 UI
  assign win_sum    = {2'b00, win_a} + {2'b00, win_b} + {2'b00, cc_edge.interval};
  assign win_sum_x3 = {1'b0, win_sum, 1'b0} + {2'b00, win_sum};
  assign thr_full   = win_sum_x3[sum_w+1:3];
  // clip so eight of them always fit the accumulator
  assign win_thr    = thr_full[iw] ? '1 : thr_full[iw-1:0];

  assign acc_sum_nxt = acc_sum + ucpd_bmc_pkg::ui_sum_t'(win_thr);

  // interval shift, only meaningful once fill says so
  always_ff @(posedge ucpd_clk) begin
    if (take && (fill != 2'd0)) begin
      win_a <= win_b;
      win_b <= cc_edge.interval;
    end
  end

  // --------------------
  // accumulate, average
  // --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      fill         <= 2'd0;
      acc_cnt      <= '0;
      acc_sum      <= '0;
      done_q       <= 1'b0;
      train_done   <= 1'b0;
      ui_threshold <= '0;
    end else begin
      train_done <= 1'b0;
      if (!train_en) begin
        fill    <= 2'd0;
        acc_cnt <= '0;
        acc_sum <= '0;
        done_q  <= 1'b0;
      end else if (take) begin
        // first interval may straddle the start of training, drop it
        if (fill != 2'd3)
          fill <= fill + 1'b1;
        if (win_ok) begin
          acc_sum <= acc_sum_nxt;
          acc_cnt <= acc_cnt + 1'b1;
          if (acc_cnt == cnt_w'(ucpd_bmc_pkg::train_samples - 1)) begin
            // divide by eight
            ui_threshold <= acc_sum_nxt[cnt_w +: iw];
            train_done   <= 1'b1;
            done_q       <= 1'b1;
          end
        end
      end
    end
  end

endmodule

/* hw/cc_line_sampler.sv */
`timescale 1ns/1ns

module cc_line_sampler #(
  parameter int IDLE_CYCLES = ucpd_bmc_pkg::default_idle_cycles
) (
  input  logic                     ucpd_clk,
  input  logic                     ic_rst_n,
  input  logic                     cc_in,
  input  ucpd_bmc_pkg::filt_mode_e filt_mode,
  output ucpd_bmc_pkg::cc_edge_t   cc_edge
);

  localparam ucpd_bmc_pkg::interval_t cnt_max  = '1;
  localparam ucpd_bmc_pkg::interval_t idle_lim = ucpd_bmc_pkg::interval_t'(IDLE_CYCLES);

  logic                    sync_1;
  logic                    sync_2;
  logic                    hist_1;
  logic                    hist_2;
  logic                    level_q;
  logic                    level_nxt;
  logic                    edge_nxt;
  logic                    edge_q;
  logic                    idle_q;
  ucpd_bmc_pkg::interval_t run_cnt;
  ucpd_bmc_pkg::interval_t interval_q;

  // --------------------
  // sync and history
  // --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      sync_1 <= 1'b0;
      sync_2 <= 1'b0;
      hist_1 <= 1'b0;
      hist_2 <= 1'b0;
    end else begin
      sync_1 <= cc_in;
      sync_2 <= sync_1;
      // older samples for the glitch filter
      hist_1 <= sync_2;
      hist_2 <= hist_1;
    end
  end

  // level moves only once the selected samples agree
  always_comb begin
    level_nxt = level_q;
    case (filt_mode)
      ucpd_bmc_pkg::filt_bypass: level_nxt = sync_2;
      ucpd_bmc_pkg::filt_2of3: begin
        if (sync_2 == hist_1)
          level_nxt = sync_2;
      end
      default: begin
        // three in a row, also used for the unused code
        if ((sync_2 == hist_1) && (hist_1 == hist_2))
          level_nxt = sync_2;
      end
    endcase
  end

  assign edge_nxt = level_nxt ^ level_q;

  // --------------------
  // edge and interval
  // --------------------
  always_ff @(posedge ucpd_clk or negedge ic_rst_n) begin
    if (!ic_rst_n) begin
      level_q <= 1'b0;
      edge_q  <= 1'b0;
      run_cnt <= '0;
      idle_q  <= 1'b0;
    end else begin
      level_q <= level_nxt;
      edge_q  <= edge_nxt;
      if (edge_nxt) begin
        // the edge cycle itself is cycle one of the next interval
        run_cnt <= ucpd_bmc_pkg::interval_t'(1);
        idle_q  <= 1'b0;
      end else begin
        if (run_cnt != cnt_max)
          run_cnt <= run_cnt + 1'b1;
        if (run_cnt >= idle_lim)
          idle_q <= 1'b1;
      end
    end
  end

  // interval snapshot, only read together with edge_pulse
  always_ff @(posedge ucpd_clk) begin
    if (edge_nxt)
      interval_q <= run_cnt;
  end

  assign cc_edge = '{edge_pulse: edge_q, level: level_q, interval: interval_q, idle: idle_q};

  // idle comes only after a stretch without any edge
  a_idle_not_on_edge: assert property (
    @(posedge ucpd_clk) disable iff (!ic_rst_n)
    $rose(idle_q) |-> !edge_q && !$past(edge_q));

endmodule

/* hw/ucpd_bmc_pkg.sv */
package ucpd_bmc_pkg;

  // --------------------
  // widths
  // --------------------
  // edge interval in ucpd_clk cycles, counter saturates at all ones
  localparam int interval_w = 11;
  // eight thresholds of interval_w bits each
  localparam int ui_sum_w   = 14;

  // --------------------
  // defaults
  // --------------------
  localparam int default_half_bit_cycles = 8;
  localparam int default_idle_cycles     = 64;
  // power of two, the average is a plain shift
  localparam int train_samples           = 8;

  typedef logic [interval_w-1:0] interval_t;
  typedef logic [ui_sum_w-1:0]   ui_sum_t;

  // cc glitch filter select
  // bit 0 set means no filter, bit 1 set means two samples
  typedef enum logic [1:0] {
    filt_3of3   = 2'b00,
    filt_bypass = 2'b01,
    filt_2of3   = 2'b10
  } filt_mode_e;

  // filtered line event, one per transition
  typedef struct packed {
    logic      edge_pulse;
    logic      level;
    interval_t interval;
    logic      idle;
  } cc_edge_t;

  // decoded bit, valid for one cycle
  typedef struct packed {
    logic valid;
    logic value;
  } rx_bit_t;

  typedef enum logic [1:0] {
    rx_idle    = 2'd0,
    rx_train   = 2'd1,
    rx_receive = 2'd2
  } rx_state_e;

endpackage
